// ==== issue_core.f ====
common/isa_pkg.sv
common/issue_pkg.sv
common/slot_if.sv
design/window/window_fill.sv
design/window/window_slot.sv
design/window/issue_select.sv
design/exec_lanes.sv
design/issue_core.sv
+incdir+bench
bench/tb_issue_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_issue_core
FILELIST  ?= issue_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard bench/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/tb_ref.svh ====
`ifndef TB_REF_SVH
`define TB_REF_SVH

// architectural state in program order
word_t model_regs [NUM_REGS];
// expected writeback values per register, oldest first
word_t exp_q [NUM_REGS][$];

function automatic word_t ref_result(instr_t instr, word_t a, word_t b);
	word_t imm_ext;
	imm_ext = {{16{instr[15]}}, instr[15:0]};
	case (opcode_t'(instr[31:26]))
		OP_ADD:  return a + b;
		OP_SUB:  return a - b;
		OP_AND:  return a & b;
		OP_OR:   return a | b;
		OP_XOR:  return a ^ b;
		OP_SLL:  return a << b[4:0];
		OP_SRL:  return a >> b[4:0];
		OP_ADDI: return a + imm_ext;
		default: return 32'h0;
	endcase
endfunction

function automatic void model_exec(instr_t instr);
	reg_idx_t rd;
	word_t    res;
	rd = instr[25:21];
	res = ref_result(instr, model_regs[instr[20:16]], model_regs[instr[15:11]]);
	// r0 stays zero and never writes back
	if (rd != 5'd0) begin
		model_regs[rd] = res;
		exp_q[rd].push_back(res);
	end
endfunction

function automatic logic queues_empty();
	for (int r = 0; r < NUM_REGS; r++) begin
		if (exp_q[r].size() != 0) begin
			return 1'b0;
		end
	end
	return 1'b1;
endfunction

`endif

// ==== bench/tb_issue_core.sv ====
`timescale 1ns/1ps
module tb_issue_core
	import isa_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 1;
	localparam int SEED = 59035;
	localparam int DENSE_PAIRS = 40;
	// independent, chain, reuse, dense, r0
	localparam int N_INSTR = 16 + 12 + 12 + 2 * DENSE_PAIRS + 8;
	localparam int WATCHDOG_CYCLES = 20 * N_INSTR + 100;

	logic     clk;
	logic     rstn;
	logic     valid0;
	logic     valid1;
	instr_t   instr0;
	instr_t   instr1;
	logic     busy;
	logic     wb0_valid;
	reg_idx_t wb0_reg;
	word_t    wb0_data;
	logic     wb1_valid;
	reg_idx_t wb1_reg;
	word_t    wb1_data;
	logic     busy_seen;
	instr_t   prog [$];

	`include "tb_ref.svh"

	issue_core dut_i (
		.clk         (clk),
		.rstn        (rstn),
		.i_valid0    (valid0),
		.i_valid1    (valid1),
		.i_instr0    (instr0),
		.i_instr1    (instr1),
		.o_busy      (busy),
		.o_wb0_valid (wb0_valid),
		.o_wb0_reg   (wb0_reg),
		.o_wb0_data  (wb0_data),
		.o_wb1_valid (wb1_valid),
		.o_wb1_reg   (wb1_reg),
		.o_wb1_data  (wb1_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic abort_run();
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	function automatic opcode_t op_at(int unsigned i);
		case (i)
			0: return OP_ADD;
			1: return OP_SUB;
			2: return OP_AND;
			3: return OP_OR;
			4: return OP_XOR;
			5: return OP_SLL;
			6: return OP_SRL;
			default: return OP_ADDI;
		endcase
	endfunction

	function automatic opcode_t rand_op(int unsigned shift_pct);
		int unsigned pick;
		if ($urandom % 100 < shift_pct) begin
			return op_at(5 + $urandom % 2);
		end
		pick = $urandom % 6;
		return op_at((pick == 5) ? 7 : pick);
	endfunction

	function automatic reg_idx_t rand_reg(int unsigned lo, int unsigned hi);
		return reg_idx_t'(lo + $urandom % (hi - lo + 1));
	endfunction

	function automatic instr_t rand_instr(opcode_t op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
		if (op == OP_ADDI) begin
			return {op, rd, rs, imm_t'($urandom)};
		end
		return {op, rd, rs, rt, 11'($urandom)};
	endfunction

	// holds the pair until a cycle with busy low takes it
	task automatic send_pair(input logic v0, input instr_t i0, input logic v1, input instr_t i1);
		logic accepted;
		accepted = 1'b0;
		valid0 = v0;
		instr0 = i0;
		valid1 = v1;
		instr1 = i1;
		while (!accepted) begin
			@(negedge clk);
			if (busy) begin
				busy_seen = 1'b1;
			end else begin
				if (v0) begin
					model_exec(i0);
				end
				if (v1) begin
					model_exec(i1);
				end
				accepted = 1'b1;
			end
			@(posedge clk);
			#(DRIVE_DELAY);
		end
	endtask

	task automatic send_prog();
		instr_t first;
		while (prog.size() > 0) begin
			first = prog.pop_front();
			if (prog.size() > 0) begin
				send_pair(1'b1, first, 1'b1, prog.pop_front());
			end else begin
				send_pair(1'b1, first, 1'b0, '0);
			end
		end
	endtask

	task automatic wait_drain();
		valid0 = 1'b0;
		valid1 = 1'b0;
		@(posedge clk);
		while (!queues_empty()) begin
			@(posedge clk);
		end
		// late duplicates would still hit an empty queue here
		repeat (4) @(posedge clk);
		#(DRIVE_DELAY);
	endtask

	task automatic check_lane(int lane, logic valid, reg_idx_t rd, word_t data);
		word_t expected;
		if (valid) begin
			assert (exp_q[rd].size() > 0) else begin
				$display("lane %0d wrote back r%0d but no result was pending", lane, rd);
				abort_run();
			end
			expected = exp_q[rd].pop_front();
			assert (data == expected) else begin
				$display("FAIL o_wb%0d_data r%0d: got %h expected %h", lane, rd, data, expected);
				abort_run();
			end
		end
	endtask

	always @(negedge clk) begin
		if (rstn) begin
			check_lane(0, wb0_valid, wb0_reg, wb0_data);
			check_lane(1, wb1_valid, wb1_reg, wb1_data);
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout, results still pending after %0d cycles", WATCHDOG_CYCLES);
		abort_run();
	end

	initial begin
		reg_idx_t prev;
		clk = 1'b0;
		rstn = 1'b0;
		valid0 = 1'b0;
		valid1 = 1'b0;
		instr0 = '0;
		instr1 = '0;
		busy_seen = 1'b0;
		void'($urandom(SEED));
		for (int r = 0; r < NUM_REGS; r++) begin
			model_regs[r] = '0;
		end
		repeat (2) @(posedge clk);
		#(DRIVE_DELAY);
		rstn = 1'b1;

		// quiet after reset
		repeat (8) begin
			@(negedge clk);
			assert (busy == 1'b0) else begin
				$display("FAIL o_busy: got %h expected %h", busy, 1'b0);
				abort_run();
			end
			assert (wb0_valid == 1'b0 && wb1_valid == 1'b0) else begin
				$display("FAIL o_wb_valid: got %h expected %h", {wb1_valid, wb0_valid}, 2'b00);
				abort_run();
			end
		end
		@(posedge clk);
		#(DRIVE_DELAY);

		// seed r1..r8 with odd ones negative, then every opcode into r9..r16
		for (int i = 1; i <= 8; i++) begin
			prog.push_back({OP_ADDI, reg_idx_t'(i), 5'd0, imm_t'($urandom) | imm_t'(i % 2 << 15)});
		end
		for (int i = 0; i < 8; i++) begin
			prog.push_back(rand_instr(op_at(i), reg_idx_t'(9 + i), rand_reg(1, 8), rand_reg(1, 8)));
		end
		prog[15][15] = 1'b1;
		send_prog();
		wait_drain();

		// dependent chain
		prev = 5'd9;
		for (int i = 0; i < 12; i++) begin
			prog.push_back(rand_instr(rand_op(20), reg_idx_t'(17 + i % 6), prev, rand_reg(1, 16)));
			prev = reg_idx_t'(17 + i % 6);
		end
		send_prog();
		wait_drain();

		// r20 written, read, rewritten
		for (int i = 0; i < 12; i++) begin
			case (i % 3)
				0: prog.push_back(rand_instr(rand_op(20), 5'd20, 5'd20, rand_reg(1, 16)));
				1: prog.push_back(rand_instr(rand_op(20), reg_idx_t'(21 + (i / 3) % 3), 5'd20,
					rand_reg(1, 16)));
				default: prog.push_back(rand_instr(rand_op(20), 5'd20, rand_reg(1, 16),
					rand_reg(21, 23)));
			endcase
		end
		send_prog();
		wait_drain();

		// shift-heavy stream that lane 0 cannot keep up with
		busy_seen = 1'b0;
		for (int p = 0; p < DENSE_PAIRS; p++) begin
			send_pair($urandom % 8 != 0,
				rand_instr(rand_op(75), rand_reg(0, 31), rand_reg(0, 31), rand_reg(0, 31)),
				$urandom % 8 != 0,
				rand_instr(rand_op(75), rand_reg(0, 31), rand_reg(0, 31), rand_reg(0, 31)));
		end
		assert (busy_seen) else begin
			$display("o_busy never went high during the dense stream");
			abort_run();
		end
		wait_drain();

		// r0 as destination and as source
		prog.push_back({OP_ADDI, 5'd0, 5'd1, 16'd77});
		prog.push_back({OP_ADD, 5'd0, 5'd2, 5'd3, 11'h0});
		prog.push_back({OP_ADD, 5'd24, 5'd0, 5'd5, 11'h0});
		prog.push_back({OP_OR, 5'd25, 5'd0, 5'd0, 11'h0});
		prog.push_back({OP_ADDI, 5'd26, 5'd0, 16'hffff});
		prog.push_back({OP_SUB, 5'd27, 5'd0, 5'd6, 11'h0});
		prog.push_back({OP_SLL, 5'd28, 5'd7, 5'd0, 11'h0});
		prog.push_back({OP_SRL, 5'd29, 5'd0, 5'd8, 11'h0});
		send_prog();
		wait_drain();

		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== design/issue_core.sv ====
`timescale 1ns/1ps
module issue_core
	import isa_pkg::*, issue_pkg::*;
(
	input  logic     clk,
	input  logic     rstn,
	input  logic     i_valid0,
	input  logic     i_valid1,
	input  instr_t   i_instr0,
	input  instr_t   i_instr1,
	output logic     o_busy,
	output logic     o_wb0_valid,
	output reg_idx_t o_wb0_reg,
	output word_t    o_wb0_data,
	output logic     o_wb1_valid,
	output reg_idx_t o_wb1_reg,
	output word_t    o_wb1_data
);

	slot_if slot_bus [SLOT_COUNT] ();

	reg_mask_t clr_mask;
	logic      go0, go1;
	opcode_t   op0, op1;
	reg_idx_t  rd0, rd1;
	reg_idx_t  rs0, rs1;
	reg_idx_t  rt0, rt1;
	imm_t      imm0, imm1;

	window_fill fill_i (
		.i_valid0 (i_valid0),
		.i_valid1 (i_valid1),
		.i_instr0 (i_instr0),
		.i_instr1 (i_instr1),
		.o_busy   (o_busy),
		.slots    (slot_bus)
	);

	for (genvar k = 0; k < SLOT_COUNT; k++) begin : g_slot
		window_slot slot_i (
			.clk  (clk),
			.rstn (rstn),
			.slot (slot_bus[k])
		);
	end

	issue_select select_i (
		.clk        (clk),
		.rstn       (rstn),
		.slots      (slot_bus),
		.i_clr_mask (clr_mask),
		.o_go0  (go0),  .o_go1  (go1),
		.o_op0  (op0),  .o_op1  (op1),
		.o_rd0  (rd0),  .o_rd1  (rd1),
		.o_rs0  (rs0),  .o_rs1  (rs1),
		.o_rt0  (rt0),  .o_rt1  (rt1),
		.o_imm0 (imm0), .o_imm1 (imm1)
	);

	exec_lanes lanes_i (
		.clk        (clk),
		.rstn       (rstn),
		.i_go0  (go0),  .i_go1  (go1),
		.i_op0  (op0),  .i_op1  (op1),
		.i_rd0  (rd0),  .i_rd1  (rd1),
		.i_rs0  (rs0),  .i_rs1  (rs1),
		.i_rt0  (rt0),  .i_rt1  (rt1),
		.i_imm0 (imm0), .i_imm1 (imm1),
		.o_clr_mask  (clr_mask),
		.o_wb0_valid (o_wb0_valid),
		.o_wb0_reg   (o_wb0_reg),
		.o_wb0_data  (o_wb0_data),
		.o_wb1_valid (o_wb1_valid),
		.o_wb1_reg   (o_wb1_reg),
		.o_wb1_data  (o_wb1_data)
	);

endmodule

// ==== design/exec_lanes.sv ====
`timescale 1ns/1ps
module exec_lanes
	import isa_pkg::*, issue_pkg::*;
(
	input  logic      clk,
	input  logic      rstn,
	input  logic      i_go0,
	input  logic      i_go1,
	input  opcode_t   i_op0,
	input  opcode_t   i_op1,
	input  reg_idx_t  i_rd0,
	input  reg_idx_t  i_rd1,
	input  reg_idx_t  i_rs0,
	input  reg_idx_t  i_rs1,
	input  reg_idx_t  i_rt0,
	input  reg_idx_t  i_rt1,
	input  imm_t      i_imm0,
	input  imm_t      i_imm1,
	output reg_mask_t o_clr_mask,
	output logic      o_wb0_valid,
	output reg_idx_t  o_wb0_reg,
	output word_t     o_wb0_data,
	output logic      o_wb1_valid,
	output reg_idx_t  o_wb1_reg,
	output word_t     o_wb1_data
);

	word_t    regs [NUM_REGS];
	logic     go   [LANE_COUNT];
	opcode_t  op   [LANE_COUNT];
	reg_idx_t rd   [LANE_COUNT];
	reg_idx_t rs   [LANE_COUNT];
	reg_idx_t rt   [LANE_COUNT];
	imm_t     imm  [LANE_COUNT];
	logic     wb_valid [LANE_COUNT];
	word_t    wb_data  [LANE_COUNT];

	function automatic word_t alu(opcode_t fn, word_t a, word_t b, imm_t k);
		case (fn)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SLL:  return a << b[4:0];
			OP_SRL:  return a >> b[4:0];
			OP_ADDI: return a + imm_sext(k);
			default: return '0;
		endcase
	endfunction

	assign go[0]  = i_go0;
	assign go[1]  = i_go1;
	assign op[0]  = i_op0;
	assign op[1]  = i_op1;
	assign rd[0]  = i_rd0;
	assign rd[1]  = i_rd1;
	assign rs[0]  = i_rs0;
	assign rs[1]  = i_rs1;
	assign rt[0]  = i_rt0;
	assign rt[1]  = i_rt1;
	assign imm[0] = i_imm0;
	assign imm[1] = i_imm1;

	for (genvar l = 0; l < LANE_COUNT; l++) begin : g_lane
		word_t opa;
		word_t opb;
		assign opa = (rs[l] == '0) ? '0 : regs[rs[l]];
		assign opb = (rt[l] == '0) ? '0 : regs[rt[l]];
		assign wb_data[l] = alu(op[l], opa, opb, imm[l]);
		// results for r0 are dropped
		assign wb_valid[l] = go[l] && rd[l] != '0;
	end

	always_comb begin
		o_clr_mask = '0;
		for (int l = 0; l < LANE_COUNT; l++) begin
			if (wb_valid[l]) begin
				o_clr_mask = o_clr_mask | reg_bit(rd[l]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				regs[r] <= '0;
			end
		end else begin
			for (int l = 0; l < LANE_COUNT; l++) begin
				if (wb_valid[l]) begin
					regs[rd[l]] <= wb_data[l];
				end
			end
		end
	end

	assign o_wb0_valid = wb_valid[0];
	assign o_wb0_reg   = rd[0];
	assign o_wb0_data  = wb_data[0];
	assign o_wb1_valid = wb_valid[1];
	assign o_wb1_reg   = rd[1];
	assign o_wb1_data  = wb_data[1];

endmodule

// ==== design/window/issue_select.sv ====
`timescale 1ns/1ps
module issue_select
	import isa_pkg::*, issue_pkg::*;
(
	input  logic      clk,
	input  logic      rstn,
	slot_if.select    slots [SLOT_COUNT],
	input  reg_mask_t i_clr_mask,
	output logic      o_go0,
	output logic      o_go1,
	output opcode_t   o_op0,
	output opcode_t   o_op1,
	output reg_idx_t  o_rd0,
	output reg_idx_t  o_rd1,
	output reg_idx_t  o_rs0,
	output reg_idx_t  o_rs1,
	output reg_idx_t  o_rt0,
	output reg_idx_t  o_rt1,
	output imm_t      o_imm0,
	output imm_t      o_imm1
);

	logic [SLOT_COUNT-1:0] valid;
	logic [SLOT_COUNT-1:0] ready;
	logic [SLOT_COUNT-1:0] taken;
	logic [SLOT_COUNT-1:0] take [LANE_COUNT];
	logic [LANE_COUNT-1:0] go_q;
	reg_mask_t  scoreboard;
	reg_mask_t  issue_dst;
	reg_mask_t  src   [SLOT_COUNT];
	reg_mask_t  dst   [SLOT_COUNT];
	unit_mask_t units [SLOT_COUNT];
	opcode_t    op    [SLOT_COUNT];
	reg_idx_t   rd    [SLOT_COUNT];
	reg_idx_t   rs    [SLOT_COUNT];
	reg_idx_t   rt    [SLOT_COUNT];
	imm_t       imm   [SLOT_COUNT];
	opcode_t    op_q  [LANE_COUNT];
	reg_idx_t   rd_q  [LANE_COUNT];
	reg_idx_t   rs_q  [LANE_COUNT];
	reg_idx_t   rt_q  [LANE_COUNT];
	imm_t       imm_q [LANE_COUNT];

	for (genvar k = 0; k < SLOT_COUNT; k++) begin : g_slot
		assign valid[k] = slots[k].valid;
		assign src[k]   = slots[k].src_mask;
		assign dst[k]   = slots[k].dst_mask;
		assign units[k] = slots[k].units;
		assign op[k]    = slots[k].op;
		assign rd[k]    = slots[k].rd;
		assign rs[k]    = slots[k].rs;
		assign rt[k]    = slots[k].rt;
		assign imm[k]   = slots[k].imm;
		assign slots[k].issued = taken[k];
	end

	// older entries block even when they issue this cycle
	always_comb begin
		reg_mask_t older_src;
		reg_mask_t older_dst;
		older_src = '0;
		older_dst = '0;
		for (int k = 0; k < SLOT_COUNT; k++) begin
			ready[k] = valid[k]
				&& ((src[k] | dst[k]) & scoreboard) == '0
				&& (src[k] & older_dst) == '0
				&& (dst[k] & (older_src | older_dst)) == '0;
			if (valid[k]) begin
				older_src = older_src | src[k];
				older_dst = older_dst | dst[k];
			end
		end
	end

	// lane 0 picks first and lane 1 gets the oldest of the rest
	always_comb begin
		logic found;
		taken = '0;
		issue_dst = '0;
		for (int l = 0; l < LANE_COUNT; l++) begin
			take[l] = '0;
			found = 1'b0;
			for (int k = 0; k < SLOT_COUNT; k++) begin
				if (!found && ready[k] && !taken[k] && units[k][l]) begin
					take[l][k] = 1'b1;
					issue_dst = issue_dst | dst[k];
					found = 1'b1;
				end
			end
			taken = taken | take[l];
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			scoreboard <= '0;
			go_q <= '0;
		end else begin
			// a register is never set and cleared in the same cycle
			scoreboard <= (scoreboard & ~i_clr_mask) | issue_dst;
			for (int l = 0; l < LANE_COUNT; l++) begin
				go_q[l] <= |take[l];
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int l = 0; l < LANE_COUNT; l++) begin
			for (int k = 0; k < SLOT_COUNT; k++) begin
				if (take[l][k]) begin
					op_q[l]  <= op[k];
					rd_q[l]  <= rd[k];
					rs_q[l]  <= rs[k];
					rt_q[l]  <= rt[k];
					imm_q[l] <= imm[k];
				end
			end
		end
	end

	assign o_go0  = go_q[0];
	assign o_go1  = go_q[1];
	assign o_op0  = op_q[0];
	assign o_op1  = op_q[1];
	assign o_rd0  = rd_q[0];
	assign o_rd1  = rd_q[1];
	assign o_rs0  = rs_q[0];
	assign o_rs1  = rs_q[1];
	assign o_rt0  = rt_q[0];
	assign o_rt1  = rt_q[1];
	assign o_imm0 = imm_q[0];
	assign o_imm1 = imm_q[1];

endmodule

// ==== design/window/window_slot.sv ====
`timescale 1ns/1ps
module window_slot
	import isa_pkg::*, issue_pkg::*;
(
	input logic  clk,
	input logic  rstn,
	slot_if.slot slot
);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			slot.valid <= 1'b0;
		end else begin
			slot.valid <= slot.nxt_valid;
		end
	end

	always_ff @(posedge clk) begin
		slot.op  <= slot.nxt_op;
		slot.rd  <= slot.nxt_rd;
		slot.rs  <= slot.nxt_rs;
		slot.rt  <= slot.nxt_rt;
		slot.imm <= slot.nxt_imm;
	end

	// addi reads rs only
	assign slot.src_mask = reg_bit(slot.rs) |
		((slot.op == OP_ADDI) ? reg_mask_t'(0) : reg_bit(slot.rt));
	assign slot.dst_mask = reg_bit(slot.rd);

	// shifter sits on lane 0 only
	assign slot.units = (slot.op == OP_SLL || slot.op == OP_SRL) ? UNIT_SHIFT : UNIT_ANY;

endmodule

// ==== design/window/window_fill.sv ====
`timescale 1ns/1ps
module window_fill
	import isa_pkg::*, issue_pkg::*;
(
	input  logic   i_valid0,
	input  logic   i_valid1,
	input  instr_t i_instr0,
	input  instr_t i_instr1,
	output logic   o_busy,
	slot_if.fill   slots [SLOT_COUNT]
);

	instr_t   in_instr [IN_COUNT];
	logic     in_valid [IN_COUNT];
	logic [SLOT_COUNT-1:0] remaining;

	// candidates in age order, held slots first
	logic     cand_valid [CAND_COUNT];
	opcode_t  cand_op    [CAND_COUNT];
	reg_idx_t cand_rd    [CAND_COUNT];
	reg_idx_t cand_rs    [CAND_COUNT];
	reg_idx_t cand_rt    [CAND_COUNT];
	imm_t     cand_imm   [CAND_COUNT];

	logic     nxt_valid [SLOT_COUNT];
	opcode_t  nxt_op    [SLOT_COUNT];
	reg_idx_t nxt_rd    [SLOT_COUNT];
	reg_idx_t nxt_rs    [SLOT_COUNT];
	reg_idx_t nxt_rt    [SLOT_COUNT];
	imm_t     nxt_imm   [SLOT_COUNT];

	assign in_instr[0] = i_instr0;
	assign in_instr[1] = i_instr1;
	assign in_valid[0] = i_valid0;
	assign in_valid[1] = i_valid1;

	// two left over means the pair might not fit
	assign o_busy = $countones(remaining) > 1;

	for (genvar k = 0; k < SLOT_COUNT; k++) begin : g_slot
		assign remaining[k]  = slots[k].valid & ~slots[k].issued;
		assign cand_valid[k] = remaining[k];
		assign cand_op[k]    = slots[k].op;
		assign cand_rd[k]    = slots[k].rd;
		assign cand_rs[k]    = slots[k].rs;
		assign cand_rt[k]    = slots[k].rt;
		assign cand_imm[k]   = slots[k].imm;
		assign slots[k].nxt_valid = nxt_valid[k];
		assign slots[k].nxt_op    = nxt_op[k];
		assign slots[k].nxt_rd    = nxt_rd[k];
		assign slots[k].nxt_rs    = nxt_rs[k];
		assign slots[k].nxt_rt    = nxt_rt[k];
		assign slots[k].nxt_imm   = nxt_imm[k];
	end

	// source holds the pair while busy
	for (genvar n = 0; n < IN_COUNT; n++) begin : g_in
		assign cand_valid[SLOT_COUNT+n] = in_valid[n] & ~o_busy;
		assign cand_op[SLOT_COUNT+n]    = instr_op(in_instr[n]);
		assign cand_rd[SLOT_COUNT+n]    = instr_rd(in_instr[n]);
		assign cand_rs[SLOT_COUNT+n]    = instr_rs(in_instr[n]);
		assign cand_rt[SLOT_COUNT+n]    = instr_rt(in_instr[n]);
		assign cand_imm[SLOT_COUNT+n]   = instr_imm(in_instr[n]);
	end

	// slot j takes the j-th live candidate
	always_comb begin
		int unsigned fill_idx;
		fill_idx = 0;
		for (int k = 0; k < SLOT_COUNT; k++) begin
			nxt_valid[k] = 1'b0;
			nxt_op[k]    = '0;
			nxt_rd[k]    = '0;
			nxt_rs[k]    = '0;
			nxt_rt[k]    = '0;
			nxt_imm[k]   = '0;
		end
		for (int c = 0; c < CAND_COUNT; c++) begin
			if (cand_valid[c] && fill_idx < SLOT_COUNT) begin
				nxt_valid[fill_idx] = 1'b1;
				nxt_op[fill_idx]    = cand_op[c];
				nxt_rd[fill_idx]    = cand_rd[c];
				nxt_rs[fill_idx]    = cand_rs[c];
				nxt_rt[fill_idx]    = cand_rt[c];
				nxt_imm[fill_idx]   = cand_imm[c];
				fill_idx = fill_idx + 1;
			end
		end
	end

endmodule

// ==== common/slot_if.sv ====
`timescale 1ns/1ps
interface slot_if
	import isa_pkg::*, issue_pkg::*;
();

	// entry loaded at the next edge
	logic       nxt_valid;
	opcode_t    nxt_op;
	reg_idx_t   nxt_rd;
	reg_idx_t   nxt_rs;
	reg_idx_t   nxt_rt;
	imm_t       nxt_imm;

	// entry held by the slot
	logic       valid;
	opcode_t    op;
	reg_idx_t   rd;
	reg_idx_t   rs;
	reg_idx_t   rt;
	imm_t       imm;
	reg_mask_t  src_mask;
	reg_mask_t  dst_mask;
	unit_mask_t units;

	logic       issued;

	modport fill (
		output nxt_valid, nxt_op, nxt_rd, nxt_rs, nxt_rt, nxt_imm,
		input  valid, op, rd, rs, rt, imm, issued
	);

	modport slot (
		input  nxt_valid, nxt_op, nxt_rd, nxt_rs, nxt_rt, nxt_imm,
		output valid, op, rd, rs, rt, imm, src_mask, dst_mask, units
	);

	modport select (
		input  valid, op, rd, rs, rt, imm, src_mask, dst_mask, units,
		output issued
	);

endinterface

// ==== common/issue_pkg.sv ====
package issue_pkg;

	localparam int SLOT_COUNT = 3;
	localparam int LANE_COUNT = 2;
	// instructions offered per cycle
	localparam int IN_COUNT = 2;
	localparam int CAND_COUNT = SLOT_COUNT + IN_COUNT;

	// one bit per lane
	typedef logic [LANE_COUNT-1:0] unit_mask_t;

	localparam unit_mask_t UNIT_ANY   = 2'b11;
	localparam unit_mask_t UNIT_SHIFT = 2'b01;

	// one bit per register with r0 always clear
	typedef logic [isa_pkg::NUM_REGS-1:0] reg_mask_t;

	function automatic reg_mask_t reg_bit(isa_pkg::reg_idx_t r);
		return (reg_mask_t'(1) << r) & ~reg_mask_t'(1);
	endfunction

endpackage

// ==== common/isa_pkg.sv ====
package isa_pkg;

	localparam int NUM_REGS = 32;

	typedef logic [31:0] instr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
	typedef logic [15:0] imm_t;
	typedef logic [31:0] word_t;

	// field positions in the instruction word
	localparam int OP_LSB = 26;
	localparam int RD_LSB = 21;
	localparam int RS_LSB = 16;
	localparam int RT_LSB = 11;
	localparam int IMM_LSB = 0;

	localparam opcode_t OP_ADD  = 6'h00;
	localparam opcode_t OP_SUB  = 6'h01;
	localparam opcode_t OP_AND  = 6'h02;
	localparam opcode_t OP_OR   = 6'h03;
	localparam opcode_t OP_XOR  = 6'h04;
	localparam opcode_t OP_SLL  = 6'h05;
	localparam opcode_t OP_SRL  = 6'h06;
	localparam opcode_t OP_ADDI = 6'h08;

	function automatic opcode_t instr_op(instr_t instr);
		return instr[OP_LSB +: $bits(opcode_t)];
	endfunction

	function automatic reg_idx_t instr_rd(instr_t instr);
		return instr[RD_LSB +: $bits(reg_idx_t)];
	endfunction

	function automatic reg_idx_t instr_rs(instr_t instr);
		return instr[RS_LSB +: $bits(reg_idx_t)];
	endfunction

	function automatic reg_idx_t instr_rt(instr_t instr);
		return instr[RT_LSB +: $bits(reg_idx_t)];
	endfunction

	// overlaps rt and only used by addi
	function automatic imm_t instr_imm(instr_t instr);
		return instr[IMM_LSB +: $bits(imm_t)];
	endfunction

	function automatic word_t imm_sext(imm_t imm);
		return {{($bits(word_t) - $bits(imm_t)){imm[$bits(imm_t)-1]}}, imm};
	endfunction

endpackage
